// ==== gpu_cfg_pkg.sv ====
package gpu_cfg_pkg;

    // ====================
    // sizes
    // ====================

    localparam int num_cores = 4;
    localparam int data_w    = 16;
    localparam int mem_aw    = 8;
    localparam int prog_aw   = 5;
    localparam int host_aw   = 10;

    // memory arbiter slots, the host takes the last one.
    localparam int num_ports = num_cores + 1;
    localparam int port_w    = $clog2(num_ports);

    // ====================
    // host address map
    // ====================

    localparam int region_w = host_aw - mem_aw;

    localparam logic [region_w-1:0] region_mem  = 'd0;
    localparam logic [region_w-1:0] region_prog = 'd1;
    localparam logic [region_w-1:0] region_ctrl = 'd2;

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [mem_aw-1:0] adr;
        logic [data_w-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [data_w-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [host_aw-1:0] adr;
        logic [data_w-1:0]  dat;
    } host_req_t;

endpackage

// ==== gpu_isa_pkg.sv ====
package gpu_isa_pkg;

    localparam int insn_w = 16;

    typedef enum logic [2:0] {
        op_addi = 3'd0,
        op_add  = 3'd1,
        op_sub  = 3'd2,
        op_ld   = 3'd3,
        op_st   = 3'd4,
        op_halt = 3'd5
    } opcode_t;

    // ====================
    // instruction layouts
    // ====================

    // register form, used by add and sub.
    typedef struct packed {
        opcode_t    op;
        logic [1:0] rd;
        logic [1:0] ra;
        logic [1:0] rb;
        logic [6:0] pad;
    } insn_reg_t;

    // immediate form, used by addi, ld and st.
    // imm is zero extended.
    typedef struct packed {
        opcode_t    op;
        logic [1:0] rd;
        logic [1:0] ra;
        logic [8:0] imm;
    } insn_imm_t;

    typedef union packed {
        insn_reg_t r;
        insn_imm_t i;
    } insn_t;

    // both layouts must cover the same word.
    localparam int insn_bits = $bits(insn_t);
    typedef logic [insn_w-1:0] insn_word_t;
    localparam insn_word_t insn_nop_halt = {op_halt, {(insn_bits - 3){1'b0}}};

endpackage

// ==== host_bridge.sv ====
module host_bridge (
    input  gpu_cfg_pkg::host_req_t top_req,
    output gpu_cfg_pkg::wb_rsp_t   top_rsp,
    output gpu_cfg_pkg::wb_req_t   mem_req,
    input  gpu_cfg_pkg::wb_rsp_t   mem_rsp,
    output gpu_cfg_pkg::wb_req_t   sched_req,
    input  gpu_cfg_pkg::wb_rsp_t   sched_rsp
);
    import gpu_cfg_pkg::*;

    logic [region_w-1:0] region;
    logic                mem_hit;
    logic                sched_hit;

    assign region    = top_req.adr[host_aw-1 -: region_w];
    assign mem_hit   = region == region_mem;
    assign sched_hit = region == region_prog || region == region_ctrl;

    always_comb begin
        mem_req.cyc = top_req.cyc && mem_hit;
        mem_req.stb = top_req.stb && mem_hit;
        mem_req.we  = top_req.we;
        mem_req.adr = top_req.adr[mem_aw-1:0];
        mem_req.dat = top_req.dat;

        // the scheduler tells program from control by the region bits on top.
        sched_req.cyc = top_req.cyc && sched_hit;
        sched_req.stb = top_req.stb && sched_hit;
        sched_req.we  = top_req.we;
        sched_req.adr = {region, top_req.adr[mem_aw-region_w-1:0]};
        sched_req.dat = top_req.dat;

        if (mem_hit) begin
            top_rsp = mem_rsp;
        end else if (sched_hit) begin
            top_rsp = sched_rsp;
        end else begin
            // unmapped space acks at once and reads zero.
            top_rsp.ack = top_req.cyc && top_req.stb;
            top_rsp.dat = '0;
        end
    end

endmodule

// ==== task_scheduler.sv ====
module task_scheduler (
    input  logic                                 clk,
    input  logic                                 arst_n,
    input  gpu_cfg_pkg::wb_req_t                 host_req,
    output gpu_cfg_pkg::wb_rsp_t                 host_rsp,
    output logic                                 prog_we,
    output logic [gpu_cfg_pkg::prog_aw-1:0]      prog_adr,
    output gpu_isa_pkg::insn_t                   prog_dat,
    output logic [gpu_cfg_pkg::num_cores-1:0]    start,
    output logic [7:0]                           task_id,
    input  logic [gpu_cfg_pkg::num_cores-1:0]    ready
);
    import gpu_cfg_pkg::*;
    import gpu_isa_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_bcast,
        st_dispatch,
        st_drain
    } state_t;

    state_t               state;
    insn_t                prog_mem [2**prog_aw];
    logic [prog_aw-1:0]   bcast_cnt;
    logic [7:0]           task_cnt;
    logic [7:0]           next_task;
    logic [num_cores-1:0] pick;
    logic                 host_acc;
    logic                 ctrl_sel;
    logic                 busy;
    logic                 ack_q;
    logic [data_w-1:0]    rd_q;

    // ====================
    // host port
    // ====================

    assign host_acc = host_req.cyc && host_req.stb && !ack_q;
    assign ctrl_sel = host_req.adr[mem_aw-1 -: region_w] == region_ctrl;
    assign busy     = state != st_idle;

    always_ff @(posedge clk) begin
        if (host_acc && host_req.we && !ctrl_sel) begin
            prog_mem[host_req.adr[prog_aw-1:0]] <= host_req.dat;
        end
        if (host_acc) begin
            rd_q <= ctrl_sel ? {{(data_w - 1){1'b0}}, busy}
                             : prog_mem[host_req.adr[prog_aw-1:0]];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= host_acc;
        end
    end

    assign host_rsp.ack = ack_q;
    assign host_rsp.dat = rd_q;

    // ====================
    // job FSM
    // ====================

    // lowest numbered ready core.
    always_comb begin
        pick = '0;
        for (int i = num_cores - 1; i >= 0; i--) begin
            if (ready[i]) begin
                pick    = '0;
                pick[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            bcast_cnt <= '0;
            task_cnt  <= '0;
            next_task <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // go is taken only here, later writes are dropped.
                    if (host_acc && host_req.we && ctrl_sel) begin
                        task_cnt  <= host_req.dat[7:0];
                        next_task <= '0;
                        bcast_cnt <= '0;
                        state     <= st_bcast;
                    end
                end
                st_bcast: begin
                    bcast_cnt <= bcast_cnt + 1'b1;
                    if (&bcast_cnt) begin
                        state <= st_dispatch;
                    end
                end
                st_dispatch: begin
                    if (next_task == task_cnt) begin
                        state <= st_drain;
                    end else if (|pick) begin
                        next_task <= next_task + 8'd1;
                    end
                end
                default: begin
                    if (&ready) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    assign prog_we  = state == st_bcast;
    assign prog_adr = bcast_cnt;
    assign prog_dat = prog_mem[bcast_cnt];
    assign start    = (state == st_dispatch && next_task != task_cnt) ? pick : '0;
    assign task_id  = next_task;

endmodule

// ==== shader_core.sv ====
module shader_core (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            prog_we,
    input  logic [gpu_cfg_pkg::prog_aw-1:0] prog_adr,
    input  gpu_isa_pkg::insn_t              prog_dat,
    input  logic                            start,
    input  logic [7:0]                      task_id,
    output logic                            ready,
    output gpu_cfg_pkg::wb_req_t            mem_req,
    input  gpu_cfg_pkg::wb_rsp_t            mem_rsp
);
    import gpu_cfg_pkg::*;
    import gpu_isa_pkg::*;

    insn_t              imem [2**prog_aw];
    logic [prog_aw-1:0] pc;
    logic [data_w-1:0]  rf [4];
    logic               running;
    insn_t              insn;
    opcode_t            op;
    logic [data_w-1:0]  imm_val;
    logic [data_w-1:0]  alu_res;
    logic               mem_op;

    // ====================
    // program copy
    // ====================

    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_adr] <= prog_dat;
        end
    end

    assign insn    = imem[pc];
    assign op      = insn.r.op;
    assign imm_val = data_w'(insn.i.imm);

    // ====================
    // execute
    // ====================

    // add and sub read the register form, the rest the immediate form.
    always_comb begin
        case (op)
            op_add:  alu_res = rf[insn.r.ra] + rf[insn.r.rb];
            op_sub:  alu_res = rf[insn.r.ra] - rf[insn.r.rb];
            default: alu_res = rf[insn.i.ra] + imm_val;
        endcase
    end

    assign mem_op = running && (op == op_ld || op == op_st);

    // request stays up until the memory acks.
    always_comb begin
        mem_req.cyc = mem_op;
        mem_req.stb = mem_op;
        mem_req.we  = op == op_st;
        mem_req.adr = alu_res[mem_aw-1:0];
        mem_req.dat = rf[insn.i.rd];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            pc      <= '0;
        end else if (start) begin
            running <= 1'b1;
            pc      <= '0;
        end else if (running) begin
            case (op)
                op_addi, op_add, op_sub: begin
                    pc <= pc + 1'b1;
                end
                op_ld, op_st: begin
                    if (mem_rsp.ack) begin
                        pc <= pc + 1'b1;
                    end
                end
                // halt, and any undefined opcode, ends the task.
                default: begin
                    running <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rf[0] <= data_w'(task_id);
            rf[1] <= '0;
            rf[2] <= '0;
            rf[3] <= '0;
        end else if (running) begin
            case (op)
                op_addi, op_add, op_sub: begin
                    rf[insn.i.rd] <= alu_res;
                end
                op_ld: begin
                    if (mem_rsp.ack) begin
                        rf[insn.i.rd] <= mem_rsp.dat;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    assign ready = !running;

endmodule

// ==== shared_mem.sv ====
module shared_mem (
    input  logic                 clk,
    input  logic                 arst_n,
    input  gpu_cfg_pkg::wb_req_t core_req [gpu_cfg_pkg::num_cores],
    output gpu_cfg_pkg::wb_rsp_t core_rsp [gpu_cfg_pkg::num_cores],
    input  gpu_cfg_pkg::wb_req_t host_req,
    output gpu_cfg_pkg::wb_rsp_t host_rsp
);
    import gpu_cfg_pkg::*;

    logic [data_w-1:0]    mem [2**mem_aw];
    wb_req_t              all_req [num_ports];
    wb_req_t              sel_req;
    logic [num_ports-1:0] req_vec;
    logic [num_ports-1:0] gnt_vec;
    logic [num_ports-1:0] ack_vec;
    logic [port_w-1:0]    last_q;
    logic [port_w-1:0]    gnt_q;
    logic [port_w-1:0]    win;
    logic                 busy;
    logic                 ack_q;
    logic [data_w-1:0]    rd_q;

    // host sits in the slot after the last core.
    always_comb begin
        for (int i = 0; i < num_cores; i++) begin
            all_req[i] = core_req[i];
        end
        all_req[num_cores] = host_req;
        for (int i = 0; i < num_ports; i++) begin
            req_vec[i] = all_req[i].cyc && all_req[i].stb;
        end
    end

    // ====================
    // round robin
    // ====================

    // the nearest requester after the last one served wins.
    always_comb begin
        int unsigned idx;
        win = last_q;
        for (int k = num_ports; k >= 1; k--) begin
            idx = (int'(last_q) + k) % num_ports;
            if (req_vec[idx]) begin
                win = port_w'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            ack_q  <= 1'b0;
            gnt_q  <= '0;
            last_q <= port_w'(num_cores);
        end else if (!busy) begin
            if (|req_vec) begin
                busy   <= 1'b1;
                gnt_q  <= win;
                last_q <= win;
            end
        end else if (!ack_q) begin
            ack_q <= 1'b1;
        end else begin
            ack_q <= 1'b0;
            busy  <= 1'b0;
        end
    end

    always_comb begin
        gnt_vec = '0;
        if (busy) begin
            gnt_vec[gnt_q] = 1'b1;
        end
    end

    assign ack_vec = ack_q ? gnt_vec : '0;
    assign sel_req = all_req[gnt_q];

    // ====================
    // array
    // ====================

    always_ff @(posedge clk) begin
        if (busy && !ack_q) begin
            if (sel_req.we) begin
                mem[sel_req.adr] <= sel_req.dat;
            end
            rd_q <= mem[sel_req.adr];
        end
    end

    always_comb begin
        for (int i = 0; i < num_cores; i++) begin
            core_rsp[i].ack = ack_vec[i];
            core_rsp[i].dat = rd_q;
        end
        host_rsp.ack = ack_vec[num_cores];
        host_rsp.dat = rd_q;
    end

endmodule

// ==== gpu_top.sv ====
module gpu_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  gpu_cfg_pkg::host_req_t host_req,
    output gpu_cfg_pkg::wb_rsp_t   host_rsp
);
    import gpu_cfg_pkg::*;
    import gpu_isa_pkg::*;

    wb_req_t              mem_host_req;
    wb_rsp_t              mem_host_rsp;
    wb_req_t              sched_req;
    wb_rsp_t              sched_rsp;
    logic                 prog_we;
    logic [prog_aw-1:0]   prog_adr;
    insn_t                prog_dat;
    logic [num_cores-1:0] start;
    logic [7:0]           task_id;
    logic [num_cores-1:0] ready;
    wb_req_t              core_req [num_cores];
    wb_rsp_t              core_rsp [num_cores];

    host_bridge bridge (
        .top_req   (host_req),
        .top_rsp   (host_rsp),
        .mem_req   (mem_host_req),
        .mem_rsp   (mem_host_rsp),
        .sched_req (sched_req),
        .sched_rsp (sched_rsp)
    );

    task_scheduler sched (
        .clk      (clk),
        .arst_n   (arst_n),
        .host_req (sched_req),
        .host_rsp (sched_rsp),
        .prog_we  (prog_we),
        .prog_adr (prog_adr),
        .prog_dat (prog_dat),
        .start    (start),
        .task_id  (task_id),
        .ready    (ready)
    );

    shared_mem mem (
        .clk      (clk),
        .arst_n   (arst_n),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .host_req (mem_host_req),
        .host_rsp (mem_host_rsp)
    );

    // program and task id are broadcast, start and ready are per core.
    for (genvar i = 0; i < num_cores; i++) begin : gen_cores
        shader_core core (
            .clk      (clk),
            .arst_n   (arst_n),
            .prog_we  (prog_we),
            .prog_adr (prog_adr),
            .prog_dat (prog_dat),
            .start    (start[i]),
            .task_id  (task_id),
            .ready    (ready[i]),
            .mem_req  (core_req[i]),
            .mem_rsp  (core_rsp[i])
        );
    end

endmodule

// ==== gpu_props.sv ====
module gpu_props (
    input logic                                clk,
    input logic                                arst_n,
    input logic [gpu_cfg_pkg::num_ports-1:0]   req_vec,
    input logic [gpu_cfg_pkg::num_ports-1:0]   gnt_vec,
    input logic [gpu_cfg_pkg::num_ports-1:0]   ack_vec
);
    timeunit 1ns;
    timeprecision 100ps;
    import gpu_cfg_pkg::*;

    for (genvar i = 0; i < num_ports; i++) begin : gen_port
        // a grant stays on its master until the ack, so no second one overlaps.
        one_grant: assert property (
            @(posedge clk) disable iff (!arst_n) gnt_vec[i] && !ack_vec[i] |=> gnt_vec[i])
            else $error("grant moved off port %0d before its ack", i);

        // ack only while the master still drives stb.
        ack_needs_stb: assert property (
            @(posedge clk) disable iff (!arst_n) ack_vec[i] |-> req_vec[i])
            else $error("ack on port %0d without stb", i);

        stb_held: assert property (
            @(posedge clk) disable iff (!arst_n) gnt_vec[i] |-> req_vec[i])
            else $error("port %0d dropped stb while granted", i);
    end

endmodule

bind shared_mem gpu_props props (
    .clk     (clk),
    .arst_n  (arst_n),
    .req_vec (req_vec),
    .gnt_vec (gnt_vec),
    .ack_vec (ack_vec)
);

// ==== tb_gpu.sv ====
module tb_gpu;
    timeunit 1ns;
    timeprecision 100ps;
    import gpu_cfg_pkg::*;
    import gpu_isa_pkg::*;

    localparam time clk_period   = 100ns;
    localparam time drive_dly    = 10ns;
    localparam int  reset_cycles = 4;
    localparam int  ack_limit    = 20;
    localparam int  poll_limit   = 200;
    localparam int  acc_cycles   = ack_limit + 3;
    localparam int  job_cycles   = poll_limit * acc_cycles;
    // host accesses per test: 32, 65, 34, 57 and 40, plus three jobs.
    localparam int  test_cycles  = 228 * acc_cycles + 3 * job_cycles;

    localparam logic [host_aw-1:0] ctrl_adr  = {region_ctrl, mem_aw'(0)};
    localparam logic [host_aw-1:0] unmap_adr = {region_w'(3), mem_aw'(0)};

    logic              clk;
    logic              arst_n;
    host_req_t         host_req;
    wb_rsp_t           host_rsp;
    logic [31:0]       rng;
    int                err_cnt;
    int                chk_cnt;
    int                test_cnt;
    int                test_err0;
    logic [data_w-1:0] vals [12];
    insn_t             prog_buf [2**prog_aw];

    gpu_top UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .host_req (host_req),
        .host_rsp (host_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // ====================
    // helpers
    // ====================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [data_w-1:0] next_word();
        rng = xorshift32(rng);
        return rng[data_w-1:0];
    endfunction

    function automatic logic [host_aw-1:0] mem_adr(input int a);
        return {region_mem, mem_aw'(a)};
    endfunction

    function automatic logic [host_aw-1:0] prog_word_adr(input int idx);
        return {region_prog, mem_aw'(idx)};
    endfunction

    function automatic insn_t enc_imm(input opcode_t op, input logic [1:0] rd,
                                      input logic [1:0] ra, input logic [8:0] imm);
        insn_t w;
        w.i.op  = op;
        w.i.rd  = rd;
        w.i.ra  = ra;
        w.i.imm = imm;
        return w;
    endfunction

    function automatic insn_t enc_reg(input opcode_t op, input logic [1:0] rd,
                                      input logic [1:0] ra, input logic [1:0] rb);
        insn_t w;
        w.r.op  = op;
        w.r.rd  = rd;
        w.r.ra  = ra;
        w.r.rb  = rb;
        w.r.pad = '0;
        return w;
    endfunction

    // ====================
    // host bus
    // ====================

    // entered just after a rising edge. ack is sampled mid cycle.
    task automatic wb_access(input logic we, input logic [host_aw-1:0] adr,
                             input logic [data_w-1:0] wdat, output logic [data_w-1:0] rdat);
        int n;
        n = 0;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = adr;
        host_req.dat = wdat;
        @(negedge clk);
        while (!host_rsp.ack && n < ack_limit) begin
            n++;
            @(negedge clk);
        end
        rdat = host_rsp.dat;
        if (!host_rsp.ack) begin
            err_cnt++;
            $display("host access to address %h got no ack", adr);
        end
        @(posedge clk);
        #(drive_dly);
        host_req = '0;
    endtask

    task automatic wb_write(input logic [host_aw-1:0] adr, input logic [data_w-1:0] dat);
        logic [data_w-1:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [host_aw-1:0] adr, output logic [data_w-1:0] dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    task automatic check_word(input string name, input logic [data_w-1:0] exp,
                              input logic [data_w-1:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_insn(input string name, input insn_t exp, input insn_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic wait_idle();
        logic [data_w-1:0] st;
        int                n;
        n  = 0;
        st = 'd1;
        while (st[0] && n < poll_limit) begin
            wb_read(ctrl_adr, st);
            n++;
        end
        if (st[0]) begin
            err_cnt++;
            $display("job still busy after %0d polls of the control register", n);
        end
    endtask

    task automatic load_program();
        for (int k = 0; k < 2**prog_aw; k++) begin
            wb_write(prog_word_adr(k), prog_buf[k]);
        end
    endtask

    task automatic fill_halt();
        for (int k = 0; k < 2**prog_aw; k++) begin
            prog_buf[k] = enc_imm(op_halt, 2'd0, 2'd0, 9'd0);
        end
    endtask

    task automatic begin_test();
        test_err0 = err_cnt;
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        $display("test %0d %s finished with %0d errors", test_cnt, name, err_cnt - test_err0);
    endtask

    // ====================
    // tests
    // ====================

    task automatic test_mem_access();
        logic [data_w-1:0] dat [16];
        logic [data_w-1:0] rd;
        begin_test();
        for (int k = 0; k < 16; k++) begin
            dat[k] = next_word();
            wb_write(mem_adr(k * 13 + 7), dat[k]);
        end
        for (int k = 0; k < 16; k++) begin
            wb_read(mem_adr(k * 13 + 7), rd);
            check_word("mem_access", dat[k], rd);
        end
        end_test("mem_access");
    endtask

    task automatic test_prog_store();
        logic [data_w-1:0] rd;
        begin_test();
        for (int k = 0; k < 2**prog_aw; k++) begin
            prog_buf[k] = insn_t'(next_word());
        end
        load_program();
        for (int k = 0; k < 2**prog_aw; k++) begin
            wb_read(prog_word_adr(k), rd);
            check_insn("prog_store", prog_buf[k], insn_t'(rd));
        end
        wb_read(unmap_adr, rd);
        check_word("prog_store_unmapped", '0, rd);
        end_test("prog_store");
    endtask

    task automatic test_single_task();
        logic [data_w-1:0] rd;
        begin_test();
        fill_halt();
        prog_buf[0] = enc_imm(op_addi, 2'd1, 2'd0, 9'd5);
        prog_buf[1] = enc_imm(op_st, 2'd1, 2'd0, 9'h080);
        load_program();
        wb_write(ctrl_adr, 16'd1);
        wait_idle();
        wb_read(mem_adr(8'h80), rd);
        check_word("single_task", 16'd5, rd);
        end_test("single_task");
    endtask

    task automatic test_many_tasks();
        logic [data_w-1:0] rd;
        logic [data_w-1:0] exp;
        begin_test();
        for (int t = 0; t < 12; t++) begin
            vals[t] = next_word();
            wb_write(mem_adr(t), vals[t]);
        end
        fill_halt();
        prog_buf[0] = enc_imm(op_ld, 2'd1, 2'd0, 9'd0);
        prog_buf[1] = enc_reg(op_add, 2'd1, 2'd1, 2'd1);
        prog_buf[2] = enc_imm(op_addi, 2'd1, 2'd1, 9'd3);
        prog_buf[3] = enc_imm(op_st, 2'd1, 2'd0, 9'h040);
        load_program();
        wb_write(ctrl_adr, 16'd12);
        wait_idle();
        for (int t = 0; t < 12; t++) begin
            exp = vals[t] + vals[t] + 16'd3;
            wb_read(mem_adr(8'h40 + t), rd);
            check_word("many_tasks", exp, rd);
        end
        end_test("many_tasks");
    endtask

    task automatic test_busy_go();
        logic [data_w-1:0] rd;
        logic [data_w-1:0] exp;
        begin_test();
        for (int t = 0; t < 16; t++) begin
            wb_write(mem_adr(8'h40 + t), '0);
        end
        wb_write(ctrl_adr, 16'd12);
        // a count of 16 would leave marks above the first 12 results.
        wb_write(ctrl_adr, 16'd16);
        wb_read(ctrl_adr, rd);
        check_word("busy_go_busy", 16'd1, rd);
        for (int t = 0; t < 4; t++) begin
            wb_read(mem_adr(t), rd);
            check_word("busy_go_host_read", vals[t], rd);
        end
        wait_idle();
        wb_read(ctrl_adr, rd);
        check_word("busy_go_idle", '0, rd);
        for (int t = 0; t < 16; t++) begin
            exp = (t < 12) ? vals[t] + vals[t] + 16'd3 : '0;
            wb_read(mem_adr(8'h40 + t), rd);
            check_word("busy_go", exp, rd);
        end
        end_test("busy_go");
    endtask

    // ====================
    // main sequence
    // ====================

    initial begin
        host_req  = '0;
        arst_n    = 1'b0;
        rng       = 32'd71;
        err_cnt   = 0;
        chk_cnt   = 0;
        test_cnt  = 0;
        test_err0 = 0;
        repeat (reset_cycles) @(posedge clk);
        #(drive_dly);
        arst_n = 1'b1;
        @(posedge clk);
        #(drive_dly);
        test_mem_access();
        test_prog_store();
        test_single_task();
        test_many_tasks();
        test_busy_go();
        $display("tests %0d checks %0d errors %0d", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(clk_period * (reset_cycles + test_cycles));
        $display("watchdog expired, tests did not complete in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== gpu_lite.f ====
gpu_cfg_pkg.sv
gpu_isa_pkg.sv
host_bridge.sv
task_scheduler.sv
shader_core.sv
shared_mem.sv
gpu_top.sv
gpu_props.sv
tb_gpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and grep the log for the result.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_gpu -f gpu_lite.f \
    && ./obj_dir/Vtb_gpu > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -qx "Simulation passed" sim.log && echo "PASS" && exit 0 || echo "FAIL" && exit 1
